/* all.f */
hw/ldqPkg.sv
hw/ldqOverlap.sv
hw/ldqEntry.sv
hw/ldqArray.sv
hw/ldqOccupancy.sv
hw/ldqTop.sv
verif/ldqTop_checker.sv
verif/ldqTb.sv

/* hw/ldqArray.sv */
`timescale 1ns/100ps
`default_nettype none

module ldqArray (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     newEn,
  input  ldqPkg::loadReq_t         newLoad,

  input  logic                     chkEn,
  input  ldqPkg::memRef_t          storeRef,

  input  logic                     retEn,
  input  logic [ldqPkg::II_W-1:0]  retIi,

  input  logic                     flushEn,
  input  logic                     flushThread,

  input  logic                     stall,

  output logic                     allocAcc,
  output logic                     allocThread,
  output logic                     retHitAcc,
  output logic                     retThread,

  output logic                     retValid,
  output ldqPkg::retireRes_t       retRes
);

  logic [ldqPkg::ENTRY_COUNT-1:0] validVec;
  logic [ldqPkg::ENTRY_COUNT-1:0] retHitVec;
  logic [ldqPkg::ENTRY_COUNT-1:0] conflVec;
  logic [ldqPkg::ENTRY_COUNT-1:0] threadVec;
  logic [ldqPkg::ENTRY_COUNT-1:0] freeSel;
  logic [ldqPkg::ENTRY_COUNT-1:0] allocVec;

  logic anyFree;
  logic newOverlap;
  logic newConfl;
  logic flushNew;
  logic retConflSel;
  logic retThreadSel;

  // lowest free entry
  always_comb begin
    freeSel = '0;
    anyFree = 1'b0;
    for (int i = 0; i < ldqPkg::ENTRY_COUNT; i++) begin
      if (!validVec[i] && !anyFree) begin
        freeSel[i] = 1'b1;
        anyFree = 1'b1;
      end
    end
  end

  // a load of the thread being flushed is lost with it
  assign flushNew = flushEn && (newLoad.thread == flushThread);

  assign allocAcc = newEn && !stall && anyFree && !flushNew;
  assign allocThread = newLoad.thread;
  assign allocVec = allocAcc ? freeSel : '0;

  ldqOverlap newOverlapInst (
    .storeRef(storeRef),
    .loadRef (newLoad.memRef),
    .overlap (newOverlap)
  );

  assign newConfl = chkEn && newOverlap;

  for (genvar e = 0; e < ldqPkg::ENTRY_COUNT; e++) begin : gEntry
    ldqEntry entryInst (
      .clk        (clk),
      .rst        (rst),
      .allocEn    (allocVec[e]),
      .allocReq   (newLoad),
      .allocConfl (newConfl),
      .chkEn      (chkEn),
      .storeRef   (storeRef),
      .retEn      (retEn),
      .retIi      (retIi),
      .flushEn    (flushEn),
      .flushThread(flushThread),
      .valid      (validVec[e]),
      .retHit     (retHitVec[e]),
      .confl      (conflVec[e]),
      .thread     (threadVec[e])
    );
  end

  // indices are distinct, so at most one entry hits
  always_comb begin
    retConflSel = 1'b0;
    retThreadSel = 1'b0;
    for (int i = 0; i < ldqPkg::ENTRY_COUNT; i++) begin
      retConflSel = retConflSel | (retHitVec[i] & conflVec[i]);
      retThreadSel = retThreadSel | (retHitVec[i] & threadVec[i]);
    end
  end

  assign retHitAcc = |retHitVec;
  assign retThread = retThreadSel;

  always_ff @(posedge clk) begin
    if (rst) begin
      retValid <= 1'b0;
    end else begin
      retValid <= retEn;
    end
  end

  always_ff @(posedge clk) begin
    retRes.hit <= retHitAcc;
    retRes.confl <= retConflSel;
  end

endmodule

`default_nettype wire

/* hw/ldqEntry.sv */
`timescale 1ns/100ps
`default_nettype none

module ldqEntry (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     allocEn,
  input  ldqPkg::loadReq_t         allocReq,
  input  logic                     allocConfl,

  input  logic                     chkEn,
  input  ldqPkg::memRef_t          storeRef,

  input  logic                     retEn,
  input  logic [ldqPkg::II_W-1:0]  retIi,

  input  logic                     flushEn,
  input  logic                     flushThread,

  output logic                     valid,
  output logic                     retHit,
  output logic                     confl,
  output logic                     thread
);

  ldqPkg::loadReq_t req;

  logic chkOverlap;
  logic chkHit;
  logic flushHit;

  ldqOverlap overlapInst (
    .storeRef(storeRef),
    .loadRef (req.memRef),
    .overlap (chkOverlap)
  );

  assign flushHit = valid && flushEn && (flushThread == req.thread);

  assign chkHit = valid && chkEn && chkOverlap;

  // a flush of our thread hides the retire match
  assign retHit = valid && retEn && (retIi == req.ii) && !flushHit;

  assign thread = req.thread;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      confl <= 1'b0;
    end else if (flushHit) begin
      valid <= 1'b0;
    end else if (allocEn) begin
      valid <= 1'b1;
      // same-cycle store already resolved by the array
      confl <= allocConfl;
    end else begin
      if (retHit) begin
        valid <= 1'b0;
      end
      if (chkHit) begin
        confl <= 1'b1;
      end
    end
  end

  // load fields
  always_ff @(posedge clk) begin
    if (allocEn) begin
      req <= allocReq;
    end
  end

endmodule

`default_nettype wire

/* hw/ldqOccupancy.sv */
`timescale 1ns/100ps
`default_nettype none

module ldqOccupancy (
  input  logic clk,
  input  logic rst,

  input  logic allocAcc,
  input  logic allocThread,

  input  logic retHitAcc,
  input  logic retThread,

  input  logic flushEn,
  input  logic flushThread,

  output logic stall
);

  logic [ldqPkg::THREAD_COUNT-1:0][ldqPkg::CNT_W-1:0] cnt;
  logic [ldqPkg::THREAD_COUNT-1:0][ldqPkg::CNT_W-1:0] cntNext;

  // one bit wider than a counter
  logic [ldqPkg::CNT_W:0] total;

  always_comb begin
    cntNext = cnt;
    total = '0;
    for (int t = 0; t < ldqPkg::THREAD_COUNT; t++) begin
      if (allocAcc && (allocThread == 1'(t))) begin
        cntNext[t] = cntNext[t] + 1'b1;
      end
      if (retHitAcc && (retThread == 1'(t))) begin
        cntNext[t] = cntNext[t] - 1'b1;
      end
      // flush overrides both
      if (flushEn && (flushThread == 1'(t))) begin
        cntNext[t] = '0;
      end
      total = total + {1'b0, cntNext[t]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      stall <= 1'b0;
    end else begin
      cnt <= cntNext;
      stall <= total >= ldqPkg::STALL_LEVEL[ldqPkg::CNT_W:0];
    end
  end

endmodule

`default_nettype wire

/* hw/ldqOverlap.sv */
`timescale 1ns/100ps
`default_nettype none

module ldqOverlap (
  input  ldqPkg::memRef_t storeRef,
  input  ldqPkg::memRef_t loadRef,
  output logic            overlap
);

  logic lineMatch;
  logic bankOverlap;
  logic byteOverlap;

  assign lineMatch = storeRef.lineAddr == loadRef.lineAddr;

  // any shared bank
  assign bankOverlap = |(storeRef.banks & loadRef.banks);

  // any shared byte inside the bank
  assign byteOverlap = |(storeRef.byteLow & loadRef.byteLow);

  assign overlap = lineMatch && bankOverlap && byteOverlap;

endmodule

`default_nettype wire

/* hw/ldqPkg.sv */
`default_nettype none

package ldqPkg;

  // queue geometry
  localparam int LINE_ADDR_W = 12;
  localparam int BANK_COUNT = 8;
  localparam int BYTE_LOW_W = 4;
  localparam int II_W = 6;
  localparam int ENTRY_COUNT = 8;
  localparam int THREAD_COUNT = 2;

  // occupancy counter wide enough for ENTRY_COUNT
  localparam int CNT_W = 4;

  // total occupancy that raises stall
  localparam int STALL_LEVEL = 6;

  // address footprint of a load or a store
  typedef struct packed {
    logic [LINE_ADDR_W-1:0] lineAddr;
    logic [BANK_COUNT-1:0] banks;
    logic [BYTE_LOW_W-1:0] byteLow;
  } memRef_t;

  typedef struct packed {
    memRef_t memRef;
    logic [II_W-1:0] ii;
    logic thread;
  } loadReq_t;

  // hit is 0 when no valid entry held the retired index
  typedef struct packed {
    logic hit;
    logic confl;
  } retireRes_t;

endpackage

`default_nettype wire

/* hw/ldqTop.sv */
`timescale 1ns/100ps
`default_nettype none

module ldqTop (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     newEn,
  input  ldqPkg::loadReq_t         newLoad,
  input  logic                     chkEn,
  input  ldqPkg::memRef_t          storeRef,
  input  logic                     retEn,
  input  logic [ldqPkg::II_W-1:0]  retIi,
  input  logic                     flushEn,
  input  logic                     flushThread,
  output logic                     stall,
  output logic                     retValid,
  output ldqPkg::retireRes_t       retRes
);

  logic allocAcc;
  logic allocThread;
  logic retHitAcc;
  logic retThread;

  ldqArray arrayInst (
    .clk        (clk),
    .rst        (rst),
    .newEn      (newEn),
    .newLoad    (newLoad),
    .chkEn      (chkEn),
    .storeRef   (storeRef),
    .retEn      (retEn),
    .retIi      (retIi),
    .flushEn    (flushEn),
    .flushThread(flushThread),
    .stall      (stall),
    .allocAcc   (allocAcc),
    .allocThread(allocThread),
    .retHitAcc  (retHitAcc),
    .retThread  (retThread),
    .retValid   (retValid),
    .retRes     (retRes)
  );

  ldqOccupancy occInst (
    .clk        (clk),
    .rst        (rst),
    .allocAcc   (allocAcc),
    .allocThread(allocThread),
    .retHitAcc  (retHitAcc),
    .retThread  (retThread),
    .flushEn    (flushEn),
    .flushThread(flushThread),
    .stall      (stall)
  );

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# build and run the load queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module ldqTb -o ldqSim

out=$(./obj_dir/ldqSim)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

/* verif/ldqTb.sv */
`timescale 1ns/100ps
`default_nettype none

module ldqTb;

  typedef enum logic [2:0] {
    opIdle,
    opLoad,
    opStore,
    opRetire,
    opFlush,
    opLoadStore
  } opcode_t;

  // one line of the stimulus file
  typedef struct packed {
    opcode_t                 op;
    ldqPkg::loadReq_t        load;
    ldqPkg::memRef_t         store;
    logic [ldqPkg::II_W-1:0] retIi;
    logic                    flushThread;
    logic                    expRetValid;
    logic                    expHit;
    logic                    expConfl;
    logic                    expStall;
  } step_t;

  localparam int MAX_STEPS = 128;
  localparam string INPUT_FILE = "verif/ldqTb_input.txt";

  logic clk = 1'b0;
  logic rst;
  logic newEn;
  ldqPkg::loadReq_t newLoad;
  logic chkEn;
  ldqPkg::memRef_t storeRef;
  logic retEn;
  logic [ldqPkg::II_W-1:0] retIi;
  logic flushEn;
  logic flushThread;
  logic stall;
  logic retValid;
  ldqPkg::retireRes_t retRes;

  step_t steps [MAX_STEPS];
  int stepCount = 0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cycleLimit = 1000;

  always #5 clk = ~clk;

  ldqTop uut (
    .clk        (clk),
    .rst        (rst),
    .newEn      (newEn),
    .newLoad    (newLoad),
    .chkEn      (chkEn),
    .storeRef   (storeRef),
    .retEn      (retEn),
    .retIi      (retIi),
    .flushEn    (flushEn),
    .flushThread(flushThread),
    .stall      (stall),
    .retValid   (retValid),
    .retRes     (retRes)
  );

  bind ldqTop ldqTopChecker checkerInst (
    .clk     (clk),
    .rst     (rst),
    .retEn   (retEn),
    .retValid(retValid),
    .stall   (stall)
  );

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout after %0d cycles with %0d errors in %0d checks",
               cycles, errors, checks);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic readSteps();
    int fd;
    int n;
    int lineNo;
    int f [15];
    logic [8*256-1:0] text;
    step_t s;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", INPUT_FILE);
      errors++;
      return;
    end
    lineNo = 0;
    while (!$feof(fd)) begin
      text = '0;
      n = $fgets(text, fd);
      lineNo++;
      if (n > 0) begin
        n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
        // comment and blank lines scan nothing
        if (n > 0) begin
          if (n != 15 || f[0] > 5) begin
            $display("malformed line %0d in the stimulus file", lineNo);
            errors++;
          end else if (stepCount >= MAX_STEPS) begin
            $display("too many lines in the stimulus file, line %0d ignored", lineNo);
            errors++;
          end else begin
            s.op = opcode_t'(f[0][2:0]);
            s.load.memRef.lineAddr = f[1][ldqPkg::LINE_ADDR_W-1:0];
            s.load.memRef.banks = f[2][ldqPkg::BANK_COUNT-1:0];
            s.load.memRef.byteLow = f[3][ldqPkg::BYTE_LOW_W-1:0];
            s.load.ii = f[4][ldqPkg::II_W-1:0];
            s.load.thread = f[5][0];
            s.store.lineAddr = f[6][ldqPkg::LINE_ADDR_W-1:0];
            s.store.banks = f[7][ldqPkg::BANK_COUNT-1:0];
            s.store.byteLow = f[8][ldqPkg::BYTE_LOW_W-1:0];
            s.retIi = f[9][ldqPkg::II_W-1:0];
            s.flushThread = f[10][0];
            s.expRetValid = f[11][0];
            s.expHit = f[12][0];
            s.expConfl = f[13][0];
            s.expStall = f[14][0];
            steps[stepCount] = s;
            stepCount++;
          end
        end
      end
    end
    $fclose(fd);
    if (stepCount == 0) begin
      $display("the stimulus file holds no steps");
      errors++;
    end
  endtask

  task automatic clearInputs();
    newEn = 1'b0;
    newLoad = '0;
    chkEn = 1'b0;
    storeRef = '0;
    retEn = 1'b0;
    retIi = '0;
    flushEn = 1'b0;
    flushThread = 1'b0;
  endtask

  task automatic driveStep(input step_t s);
    clearInputs();
    newLoad = s.load;
    storeRef = s.store;
    retIi = s.retIi;
    flushThread = s.flushThread;
    case (s.op)
      opLoad: newEn = 1'b1;
      opStore: chkEn = 1'b1;
      opRetire: retEn = 1'b1;
      opFlush: flushEn = 1'b1;
      opLoadStore: begin
        newEn = 1'b1;
        chkEn = 1'b1;
      end
      default: ;
    endcase
  endtask

  // outputs seen after the edge that took the step
  task automatic checkStep(input int idx, input step_t s);
    checks++;
    assert (retValid === s.expRetValid) else begin
      errors++;
      $display("CHECK FAILED step %0d: retValid got %h expected %h",
               idx, retValid, s.expRetValid);
    end
    if (s.expRetValid) begin
      checks += 2;
      assert (retRes.hit === s.expHit) else begin
        errors++;
        $display("CHECK FAILED step %0d: retRes.hit got %h expected %h",
                 idx, retRes.hit, s.expHit);
      end
      assert (retRes.confl === s.expConfl) else begin
        errors++;
        $display("CHECK FAILED step %0d: retRes.confl got %h expected %h",
                 idx, retRes.confl, s.expConfl);
      end
    end
    checks++;
    assert (stall === s.expStall) else begin
      errors++;
      $display("CHECK FAILED step %0d: stall got %h expected %h",
               idx, stall, s.expStall);
    end
  endtask

  initial begin
    rst = 1'b1;
    clearInputs();
    readSteps();
    cycleLimit = 2 * stepCount + 20;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < stepCount; i++) begin
      driveStep(steps[i]);
      @(negedge clk);
      checkStep(i, steps[i]);
    end
    clearInputs();
    $display("errors: %0d in %0d checks over %0d steps", errors, checks, stepCount);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/ldqTb_input.txt */
# op ldLine ldBanks ldBytes ldIi ldThread stLine stBanks stBytes retIi flThread rv hit confl stall
# op 0 idle 1 load 2 store 3 retire 4 flush 5 load+store, all hex, last four are expected
# load then retire
1 100 01 3 01 0 000 00 0 00 0 0 0 0 0
3 000 00 0 00 0 000 00 0 01 0 1 1 0 0
# store matches, then line, bank and byte misses
1 200 0c 6 02 0 000 00 0 00 0 0 0 0 0
1 300 30 9 03 0 000 00 0 00 0 0 0 0 0
1 400 c0 c 04 1 000 00 0 00 0 0 0 0 0
2 000 00 0 00 0 200 04 2 00 0 0 0 0 0
2 000 00 0 00 0 301 30 9 00 0 0 0 0 0
2 000 00 0 00 0 300 0f 9 00 0 0 0 0 0
2 000 00 0 00 0 400 c0 3 00 0 0 0 0 0
3 000 00 0 00 0 000 00 0 02 0 1 1 1 0
3 000 00 0 00 0 000 00 0 03 0 1 1 0 0
3 000 00 0 00 0 000 00 0 04 0 1 1 0 0
# load and store in one cycle
5 500 02 1 05 1 500 03 f 00 0 0 0 0 0
5 600 01 1 06 0 600 02 1 00 0 0 0 0 0
3 000 00 0 00 0 000 00 0 05 0 1 1 1 0
3 000 00 0 00 0 000 00 0 06 0 1 1 0 0
# flush of thread 1
1 700 01 1 07 1 000 00 0 00 0 0 0 0 0
1 701 01 1 08 0 000 00 0 00 0 0 0 0 0
1 702 01 1 09 1 000 00 0 00 0 0 0 0 0
2 000 00 0 00 0 700 01 1 00 0 0 0 0 0
4 000 00 0 00 0 000 00 0 00 1 0 0 0 0
3 000 00 0 00 0 000 00 0 07 0 1 0 0 0
3 000 00 0 00 0 000 00 0 09 0 1 0 0 0
3 000 00 0 00 0 000 00 0 08 0 1 1 0 0
# six loads raise stall, seventh is dropped
1 800 01 1 0a 0 000 00 0 00 0 0 0 0 0
1 801 01 1 0b 1 000 00 0 00 0 0 0 0 0
1 802 01 1 0c 0 000 00 0 00 0 0 0 0 0
1 803 01 1 0d 1 000 00 0 00 0 0 0 0 0
1 804 01 1 0e 0 000 00 0 00 0 0 0 0 0
1 805 01 1 0f 1 000 00 0 00 0 0 0 0 1
1 806 01 1 10 0 000 00 0 00 0 0 0 0 1
3 000 00 0 00 0 000 00 0 10 0 1 0 0 1
3 000 00 0 00 0 000 00 0 0a 0 1 1 0 0
3 000 00 0 00 0 000 00 0 0b 0 1 1 0 0
3 000 00 0 00 0 000 00 0 0c 0 1 1 0 0
3 000 00 0 00 0 000 00 0 0d 0 1 1 0 0
3 000 00 0 00 0 000 00 0 0e 0 1 1 0 0
3 000 00 0 00 0 000 00 0 0f 0 1 1 0 0
1 900 01 1 11 1 000 00 0 00 0 0 0 0 0
3 000 00 0 00 0 000 00 0 11 0 1 1 0 0
# index held by no entry
3 000 00 0 00 0 000 00 0 3f 0 1 0 0 0
0 000 00 0 00 0 000 00 0 00 0 0 0 0 0
0 000 00 0 00 0 000 00 0 00 0 0 0 0 0

/* verif/ldqTop_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module ldqTopChecker (
  input logic clk,
  input logic rst,
  input logic retEn,
  input logic retValid,
  input logic stall
);

  // outputs leave reset low
  resetLow: assert property (@(posedge clk) rst |=> (!stall && !retValid))
    else $error("stall or retValid high in the cycle after reset");

  // retire result exactly one cycle after the request
  retFollows: assert property (@(posedge clk) disable iff (rst)
    retEn |=> retValid)
    else $error("retValid missing one cycle after retEn");

  noSpuriousRet: assert property (@(posedge clk) disable iff (rst)
    $rose(retValid) |-> $past(retEn))
    else $error("retValid rose without a retEn one cycle earlier");

endmodule

`default_nettype wire
